// File: rtl/dmc_consts.svh
`ifndef DMC_CONSTS_SVH
`define DMC_CONSTS_SVH

// Command codes as {cs_n, ras_n, cas_n, we_n}
`define DMC_LMR   4'b0000
`define DMC_REF   4'b0001
`define DMC_PRE   4'b0010
`define DMC_ACT   4'b0011
`define DMC_WRITE 4'b0100
`define DMC_READ  4'b0101
`define DMC_NOP   4'b0111

`define DMC_NUM_BANKS   8
`define DMC_QUEUE_DEPTH 4

// DFI beats per burst; the LMR burst field is log2 of twice this
`define DMC_BURST_LEN 4
`define DMC_LMR_BL    ($clog2(`DMC_BURST_LEN * 2))

// Timing in dfi_clk cycles
`define DMC_TMRD 2
`define DMC_TRFC 10
`define DMC_TRP  3
`define DMC_TRAS 6
`define DMC_TRRD 2
`define DMC_TRCD 3
`define DMC_TWR  3
`define DMC_TWTR 2
`define DMC_TRTP 2
`define DMC_TRC  9
`define DMC_TCAS 3

`define DMC_TREFI     200
`define DMC_INIT_CMDS 6

// A10 selects all banks on PRE and auto-precharge on READ/WRITE
`define DMC_PRE_ALL_BIT 10

`endif

// File: rtl/dmc_pkg.sv
`default_nettype none

package dmc_pkg;

  typedef logic [2:0]  bank_t;
  typedef logic [15:0] row_t;
  typedef logic [9:0]  col_t;
  // {bank, row, col}
  typedef logic [28:0] addr_t;
  // {cs_n, ras_n, cas_n, we_n}
  typedef logic [3:0]  cmd_code_t;
  typedef logic [7:0]  tick_t;

  typedef enum logic [1:0] {
    IDLE,
    INIT,
    REFR,
    LDST
  } seq_state_e;

endpackage

`default_nettype wire

// File: rtl/dmc_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dmc_cmd_if;

  logic               valid;
  logic               ready;
  logic               cke;
  dmc_pkg::cmd_code_t code;
  dmc_pkg::bank_t     bank;
  dmc_pkg::row_t      addr;

  modport producer (
    output valid, cke, code, bank, addr,
    input  ready
  );

  modport consumer (
    input  valid, cke, code, bank, addr,
    output ready
  );

  // Watches transfers without taking part in the handshake
  modport monitor (
    input valid, ready, cke, code, bank, addr
  );

endinterface

`default_nettype wire

// File: rtl/dmc_cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmc_consts.svh"

module dmc_cmd_sequencer (
  input  wire                 dfi_clk_i,
  input  wire                 dfi_clk_sync_rst_i,
  input  wire dmc_pkg::addr_t app_addr_i,
  input  wire                 app_write_i,
  input  wire                 app_ap_i,
  input  wire                 app_en_i,
  output logic                app_rdy_o,
  output logic                init_calib_complete_o,
  input  wire [`DMC_NUM_BANKS-1:0] bank_open_i,
  input  wire dmc_pkg::row_t  bank_row_i [`DMC_NUM_BANKS],
  dmc_cmd_if.producer         push_o
);

  dmc_pkg::seq_state_e state_q;
  dmc_pkg::seq_state_e state_d;
  logic                init_done_q;
  logic [2:0]          init_tick_q;
  logic                refr_tick_q;
  logic [1:0]          ldst_tick_q;
  logic [15:0]         refi_cnt_q;
  logic                refr_req_q;
  logic                req_held_q;
  dmc_pkg::addr_t      req_addr_q;
  logic                req_write_q;
  logic                req_ap_q;
  dmc_pkg::bank_t      req_bank;
  dmc_pkg::row_t       req_row;
  dmc_pkg::col_t       req_col;
  dmc_pkg::row_t       col_addr;
  logic                row_hit;
  logic                push;
  logic                last_tick;

  assign {req_bank, req_row, req_col} = req_addr_q;
  assign col_addr = dmc_pkg::row_t'(req_col)
                  | (dmc_pkg::row_t'(req_ap_q) << `DMC_PRE_ALL_BIT);
  assign row_hit  = bank_open_i[req_bank] && (bank_row_i[req_bank] == req_row);

  assign app_rdy_o = (state_q == dmc_pkg::IDLE) && init_done_q && !refr_req_q && !req_held_q;
  assign init_calib_complete_o = init_done_q;

  assign push_o.valid = (state_q != dmc_pkg::IDLE) && push_o.ready;
  assign push_o.cke   = 1'b1;
  assign push         = push_o.valid;

  always_ff @(posedge dfi_clk_i) begin
    if (app_en_i && app_rdy_o) begin
      req_addr_q  <= app_addr_i;
      req_write_q <= app_write_i;
      req_ap_q    <= app_ap_i;
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      state_q     <= dmc_pkg::IDLE;
      init_done_q <= 1'b0;
      req_held_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == dmc_pkg::INIT && push && last_tick)
        init_done_q <= 1'b1;
      if (app_en_i && app_rdy_o)
        req_held_q <= 1'b1;
      else if (state_q == dmc_pkg::LDST && push && last_tick)
        req_held_q <= 1'b0;
    end
  end

  // Ticks are loaded while idle, from bank state that is already up to date
  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      init_tick_q <= '0;
      refr_tick_q <= 1'b0;
      ldst_tick_q <= '0;
    end else if (state_q == dmc_pkg::IDLE) begin
      init_tick_q <= 3'(`DMC_INIT_CMDS - 1);
      refr_tick_q <= |bank_open_i;
      if (!bank_open_i[req_bank])
        ldst_tick_q <= 2'd1;
      else if (row_hit)
        ldst_tick_q <= 2'd0;
      else
        ldst_tick_q <= 2'd2;
    end else if (push) begin
      init_tick_q <= init_tick_q - 3'd1;
      refr_tick_q <= 1'b0;
      ldst_tick_q <= ldst_tick_q - 2'd1;
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      refi_cnt_q <= '0;
      refr_req_q <= 1'b0;
    end else if (init_done_q) begin
      if (refi_cnt_q == 16'(`DMC_TREFI))
        refi_cnt_q <= '0;
      else if (!refr_req_q)
        refi_cnt_q <= refi_cnt_q + 16'd1;
      if (state_q == dmc_pkg::REFR && push && last_tick)
        refr_req_q <= 1'b0;
      else if (refi_cnt_q == 16'(`DMC_TREFI))
        refr_req_q <= 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    if (state_q == dmc_pkg::IDLE) begin
      if (!init_done_q)
        state_d = dmc_pkg::INIT;
      else if (refr_req_q)
        state_d = dmc_pkg::REFR;
      else if (req_held_q)
        state_d = dmc_pkg::LDST;
    end else if (push && last_tick) begin
      state_d = dmc_pkg::IDLE;
    end
  end

  always_comb begin
    push_o.code = `DMC_NOP;
    push_o.bank = '0;
    push_o.addr = '0;
    last_tick   = 1'b0;
    case (state_q)
      dmc_pkg::INIT: begin
        last_tick = (init_tick_q == 3'd0);
        case (init_tick_q)
          3'd4: begin
            push_o.code = `DMC_PRE;
            push_o.addr = dmc_pkg::row_t'(1) << `DMC_PRE_ALL_BIT;
          end
          3'd3, 3'd2: push_o.code = `DMC_REF;
          // Mode register with CAS latency and burst length
          3'd1: begin
            push_o.code = `DMC_LMR;
            push_o.addr = {8'h00, 4'(`DMC_TCAS), 4'(`DMC_LMR_BL)};
          end
          3'd0: begin
            push_o.code = `DMC_LMR;
            push_o.bank = 3'd2;
          end
          default: push_o.code = `DMC_NOP;
        endcase
      end
      dmc_pkg::REFR: begin
        last_tick = !refr_tick_q;
        if (refr_tick_q) begin
          push_o.code = `DMC_PRE;
          push_o.addr = dmc_pkg::row_t'(1) << `DMC_PRE_ALL_BIT;
        end else begin
          push_o.code = `DMC_REF;
        end
      end
      dmc_pkg::LDST: begin
        last_tick   = (ldst_tick_q == 2'd0);
        push_o.bank = req_bank;
        case (ldst_tick_q)
          2'd2: push_o.code = `DMC_PRE;
          2'd1: begin
            push_o.code = `DMC_ACT;
            push_o.addr = req_row;
          end
          default: begin
            push_o.code = req_write_q ? `DMC_WRITE : `DMC_READ;
            push_o.addr = col_addr;
          end
        endcase
      end
      default: last_tick = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/dmc_bank_tracker.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmc_consts.svh"

module dmc_bank_tracker #(
  parameter dmc_pkg::bank_t bank_id_p = '0
) (
  input  wire           dfi_clk_i,
  input  wire           dfi_clk_sync_rst_i,
  dmc_cmd_if.monitor    mon_i,
  output logic          open_o,
  output dmc_pkg::row_t row_o
);

  logic fire;
  logic hit;
  logic a10;

  // Only commands with cke high change the bank state
  assign fire = mon_i.valid && mon_i.ready && mon_i.cke;
  assign hit  = (mon_i.bank == bank_id_p);
  assign a10  = mon_i.addr[`DMC_PRE_ALL_BIT];

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      open_o <= 1'b0;
    end else if (fire) begin
      case (mon_i.code)
        `DMC_ACT: begin
          if (hit)
            open_o <= 1'b1;
        end
        `DMC_READ, `DMC_WRITE: begin
          if (hit && a10)
            open_o <= 1'b0;
        end
        `DMC_PRE: begin
          if (hit || a10)
            open_o <= 1'b0;
        end
        default: open_o <= open_o;
      endcase
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (fire && hit && mon_i.code == `DMC_ACT)
      row_o <= mon_i.addr;
  end

endmodule

`default_nettype wire

// File: rtl/dmc_cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmc_consts.svh"

module dmc_cmd_queue (
  input  wire         dfi_clk_i,
  input  wire         dfi_clk_sync_rst_i,
  dmc_cmd_if.consumer in_i,
  dmc_cmd_if.producer out_o
);

  localparam int ptr_w_lp   = $clog2(`DMC_QUEUE_DEPTH);
  // Entry is {cke, code, bank, addr}
  localparam int entry_w_lp = 1 + $bits(dmc_pkg::cmd_code_t) + $bits(dmc_pkg::bank_t)
                            + $bits(dmc_pkg::row_t);

  logic [entry_w_lp-1:0] mem_q [`DMC_QUEUE_DEPTH];
  logic [ptr_w_lp-1:0]   wr_ptr_q;
  logic [ptr_w_lp-1:0]   rd_ptr_q;
  logic [ptr_w_lp:0]     count_q;
  logic                  push;
  logic                  pop;

  function automatic logic [ptr_w_lp-1:0] ptr_next(input logic [ptr_w_lp-1:0] ptr);
    return (ptr == ptr_w_lp'(`DMC_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_i.ready  = (count_q < (ptr_w_lp + 1)'(`DMC_QUEUE_DEPTH));
  assign out_o.valid = (count_q != '0);
  assign push        = in_i.valid && in_i.ready;
  assign pop         = out_o.valid && out_o.ready;

  assign {out_o.cke, out_o.code, out_o.bank, out_o.addr} = mem_q[rd_ptr_q];

  always_ff @(posedge dfi_clk_i) begin
    if (push)
      mem_q[wr_ptr_q] <= {in_i.cke, in_i.code, in_i.bank, in_i.addr};
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push)
        wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop)
        rd_ptr_q <= ptr_next(rd_ptr_q);
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/dmc_cmd_issuer.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmc_consts.svh"

module dmc_cmd_issuer (
  input  wire            dfi_clk_i,
  input  wire            dfi_clk_sync_rst_i,
  dmc_cmd_if.consumer    cmd_i,
  output dmc_pkg::bank_t dfi_bank_o,
  output dmc_pkg::row_t  dfi_address_o,
  output logic           dfi_cke_o,
  output logic           dfi_cs_n_o,
  output logic           dfi_ras_n_o,
  output logic           dfi_cas_n_o,
  output logic           dfi_we_n_o,
  output logic           dfi_wrdata_en_o,
  output logic           dfi_rddata_en_o
);

  localparam dmc_pkg::tick_t tick_max_lp   = 8'd15;
  localparam dmc_pkg::tick_t burst_last_lp = 8'(`DMC_BURST_LEN - 1);
  // Delay from shoot to strobe start, index 0 for write and 1 for read
  localparam dmc_pkg::tick_t strb_dly_lp [2] = '{8'(`DMC_TCAS - 1), 8'(`DMC_TCAS)};

  dmc_pkg::cmd_code_t p_cmd_q;
  dmc_pkg::cmd_code_t n_cmd;
  dmc_pkg::tick_t     cmd_tick_q;
  dmc_pkg::tick_t     act_tick_q;
  dmc_pkg::tick_t     wr_tick_q;
  dmc_pkg::tick_t     rd_tick_q;
  dmc_pkg::tick_t     strb_dly_q [2];
  dmc_pkg::tick_t     strb_len_q [2];
  logic [1:0]         strb_start;
  logic               shoot;

  function automatic dmc_pkg::tick_t sat_inc(input dmc_pkg::tick_t tick);
    return (tick == tick_max_lp) ? tick : tick + 8'd1;
  endfunction

  assign n_cmd       = cmd_i.code;
  assign cmd_i.ready = shoot;

  // Spacing rules keyed on the previous and the next command
  always_comb begin
    shoot = 1'b1;
    case (p_cmd_q)
      `DMC_LMR: shoot = (cmd_tick_q >= `DMC_TMRD);
      `DMC_REF: shoot = (cmd_tick_q >= `DMC_TRFC);
      `DMC_PRE: begin
        shoot = (cmd_tick_q >= `DMC_TRP);
        if (n_cmd == `DMC_ACT)
          shoot = shoot && (act_tick_q >= `DMC_TRAS);
      end
      `DMC_ACT: begin
        case (n_cmd)
          `DMC_PRE:   shoot = (cmd_tick_q >= `DMC_TRAS);
          `DMC_ACT:   shoot = (cmd_tick_q >= `DMC_TRRD);
          `DMC_WRITE: shoot = (cmd_tick_q >= `DMC_TRCD)
                           && (rd_tick_q >= `DMC_TCAS + burst_last_lp);
          `DMC_READ:  shoot = (cmd_tick_q >= `DMC_TRCD) && (wr_tick_q >= `DMC_TWTR);
          default:    shoot = 1'b1;
        endcase
      end
      `DMC_WRITE: begin
        case (n_cmd)
          `DMC_PRE:   shoot = (cmd_tick_q >= `DMC_TWR) && (act_tick_q >= `DMC_TRAS);
          `DMC_WRITE: shoot = (cmd_tick_q >= burst_last_lp);
          `DMC_READ:  shoot = (cmd_tick_q >= `DMC_TWTR);
          `DMC_ACT:   shoot = (act_tick_q >= `DMC_TRC)
                           && (cmd_tick_q >= `DMC_TWR + `DMC_TRP);
          default:    shoot = 1'b1;
        endcase
      end
      `DMC_READ: begin
        case (n_cmd)
          `DMC_PRE:   shoot = (cmd_tick_q >= `DMC_TRTP) && (act_tick_q >= `DMC_TRAS);
          `DMC_WRITE: shoot = (cmd_tick_q >= burst_last_lp + `DMC_TCAS);
          `DMC_READ:  shoot = (cmd_tick_q >= burst_last_lp);
          `DMC_ACT:   shoot = (act_tick_q >= `DMC_TRC)
                           && (cmd_tick_q >= `DMC_TRTP + `DMC_TRP);
          default:    shoot = 1'b1;
        endcase
      end
      default: shoot = 1'b1;
    endcase
    shoot = shoot && cmd_i.valid;
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      p_cmd_q    <= `DMC_NOP;
      cmd_tick_q <= '0;
      act_tick_q <= '0;
      wr_tick_q  <= '0;
      rd_tick_q  <= '0;
    end else begin
      cmd_tick_q <= shoot ? '0 : sat_inc(cmd_tick_q);
      act_tick_q <= (shoot && n_cmd == `DMC_ACT) ? '0 : sat_inc(act_tick_q);
      wr_tick_q  <= (shoot && n_cmd == `DMC_WRITE) ? '0 : sat_inc(wr_tick_q);
      rd_tick_q  <= (shoot && n_cmd == `DMC_READ) ? '0 : sat_inc(rd_tick_q);
      if (shoot)
        p_cmd_q <= n_cmd;
    end
  end

  // Pins fall back to NOP whenever nothing is shot
  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      dfi_bank_o    <= '0;
      dfi_address_o <= '0;
      dfi_cke_o     <= 1'b0;
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= 4'b1111;
    end else if (shoot) begin
      dfi_bank_o    <= cmd_i.bank;
      dfi_address_o <= cmd_i.addr;
      dfi_cke_o     <= cmd_i.cke;
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= n_cmd;
    end else begin
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= 4'b1111;
    end
  end

  assign strb_start[0] = shoot && (n_cmd == `DMC_WRITE);
  assign strb_start[1] = shoot && (n_cmd == `DMC_READ);

  // Delay countdown hands over to a burst-long countdown
  always_ff @(posedge dfi_clk_i) begin
    for (int i = 0; i < 2; i++) begin
      if (dfi_clk_sync_rst_i) begin
        strb_dly_q[i] <= '0;
        strb_len_q[i] <= '0;
      end else begin
        if (strb_start[i])
          strb_dly_q[i] <= strb_dly_lp[i];
        else if (strb_dly_q[i] != '0)
          strb_dly_q[i] <= strb_dly_q[i] - 8'd1;
        if (strb_dly_q[i] == 8'd1)
          strb_len_q[i] <= 8'(`DMC_BURST_LEN);
        else if (strb_len_q[i] != '0)
          strb_len_q[i] <= strb_len_q[i] - 8'd1;
      end
    end
  end

  assign dfi_wrdata_en_o = (strb_len_q[0] != '0);
  assign dfi_rddata_en_o = (strb_len_q[1] != '0);

endmodule

`default_nettype wire

// File: rtl/dmc_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmc_consts.svh"

module dmc_top (
  input  wire                 dfi_clk_i,
  input  wire                 dfi_clk_sync_rst_i,
  input  wire dmc_pkg::addr_t app_addr_i,
  input  wire                 app_write_i,
  input  wire                 app_ap_i,
  input  wire                 app_en_i,
  output wire                 app_rdy_o,
  output wire                 init_calib_complete_o,
  output wire dmc_pkg::bank_t dfi_bank_o,
  output wire dmc_pkg::row_t  dfi_address_o,
  output wire                 dfi_cke_o,
  output wire                 dfi_cs_n_o,
  output wire                 dfi_ras_n_o,
  output wire                 dfi_cas_n_o,
  output wire                 dfi_we_n_o,
  output wire                 dfi_wrdata_en_o,
  output wire                 dfi_rddata_en_o
);

  wire [`DMC_NUM_BANKS-1:0] bank_open;
  dmc_pkg::row_t            bank_row [`DMC_NUM_BANKS];

  dmc_cmd_if push_bus ();
  dmc_cmd_if issue_bus ();

  dmc_cmd_sequencer u_sequencer (
    .dfi_clk_i             (dfi_clk_i),
    .dfi_clk_sync_rst_i    (dfi_clk_sync_rst_i),
    .app_addr_i            (app_addr_i),
    .app_write_i           (app_write_i),
    .app_ap_i              (app_ap_i),
    .app_en_i              (app_en_i),
    .app_rdy_o             (app_rdy_o),
    .init_calib_complete_o (init_calib_complete_o),
    .bank_open_i           (bank_open),
    .bank_row_i            (bank_row),
    .push_o                (push_bus.producer)
  );

  for (genvar i = 0; i < `DMC_NUM_BANKS; i++) begin : g_bank
    dmc_bank_tracker #(
      .bank_id_p (dmc_pkg::bank_t'(i))
    ) u_tracker (
      .dfi_clk_i          (dfi_clk_i),
      .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
      .mon_i              (push_bus.monitor),
      .open_o             (bank_open[i]),
      .row_o              (bank_row[i])
    );
  end

  dmc_cmd_queue u_queue (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .in_i               (push_bus.consumer),
    .out_o              (issue_bus.producer)
  );

  dmc_cmd_issuer u_issuer (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .cmd_i              (issue_bus.consumer),
    .dfi_bank_o         (dfi_bank_o),
    .dfi_address_o      (dfi_address_o),
    .dfi_cke_o          (dfi_cke_o),
    .dfi_cs_n_o         (dfi_cs_n_o),
    .dfi_ras_n_o        (dfi_ras_n_o),
    .dfi_cas_n_o        (dfi_cas_n_o),
    .dfi_we_n_o         (dfi_we_n_o),
    .dfi_wrdata_en_o    (dfi_wrdata_en_o),
    .dfi_rddata_en_o    (dfi_rddata_en_o)
  );

endmodule

`default_nettype wire

// File: test/tb_dmc_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmc_consts.svh"

module tb_dmc_top;

  localparam int num_rand_req_lp = 40;
  localparam int num_req_lp      = num_rand_req_lp + 3;
  localparam int idle_cycles_lp  = 1000;
  localparam int watchdog_lp     = num_req_lp * 60 + 2000;
  localparam int ring_lp         = 64;
  // Marks an unused slot of an expected command list
  localparam logic [22:0] no_cmd_lp = {4'hF, 19'h0};

  logic           dfi_clk = 1'b0;
  logic           dfi_clk_sync_rst;
  dmc_pkg::addr_t app_addr;
  logic           app_write;
  logic           app_ap;
  logic           app_en;
  logic           app_rdy;
  logic           init_calib_complete;
  dmc_pkg::bank_t dfi_bank;
  dmc_pkg::row_t  dfi_address;
  logic           dfi_cke;
  logic           dfi_cs_n;
  logic           dfi_ras_n;
  logic           dfi_cas_n;
  logic           dfi_we_n;
  logic           dfi_wrdata_en;
  logic           dfi_rddata_en;

  logic [31:0]    lfsr_q;
  int             cycle_cnt = 0;
  // Recorded commands are {code, bank, address}
  logic [22:0]    mon_q [$];
  int             mon_cyc_q [$];
  // Accepted requests are {write, ap, addr}
  logic [30:0]    req_q [$];
  logic [22:0]    exp_q [$];
  logic           exp_rd [ring_lp];
  logic           exp_wr [ring_lp];
  logic           model_open [`DMC_NUM_BANKS];
  dmc_pkg::row_t  model_row [`DMC_NUM_BANKS];
  int             errs [5] = '{0, 0, 0, 0, 0};
  string          test_names [5] = '{"reset and init", "request commands",
                                     "command spacing", "refresh", "data enables"};
  int             init_seen = 0;
  int             reqs_done = 0;
  int             idle_refs = 0;
  logic           idle_phase = 1'b0;

  dmc_top uut (
    .dfi_clk_i             (dfi_clk),
    .dfi_clk_sync_rst_i    (dfi_clk_sync_rst),
    .app_addr_i            (app_addr),
    .app_write_i           (app_write),
    .app_ap_i              (app_ap),
    .app_en_i              (app_en),
    .app_rdy_o             (app_rdy),
    .init_calib_complete_o (init_calib_complete),
    .dfi_bank_o            (dfi_bank),
    .dfi_address_o         (dfi_address),
    .dfi_cke_o             (dfi_cke),
    .dfi_cs_n_o            (dfi_cs_n),
    .dfi_ras_n_o           (dfi_ras_n),
    .dfi_cas_n_o           (dfi_cas_n),
    .dfi_we_n_o            (dfi_we_n),
    .dfi_wrdata_en_o       (dfi_wrdata_en),
    .dfi_rddata_en_o       (dfi_rddata_en)
  );

  always #4 dfi_clk = ~dfi_clk;

  always @(posedge dfi_clk) cycle_cnt <= cycle_cnt + 1;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check(input int cat, input string name, input logic [31:0] got,
                       input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cycle_cnt);
      errs[cat]++;
    end
  endtask

  task automatic note_failure(input int cat, input string msg);
    $display("ERROR at cycle %0d: %s", cycle_cnt, msg);
    errs[cat]++;
  endtask

  task automatic compare_cmd(input int cat, input logic [22:0] got, input logic [22:0] exp);
    check(cat, "dfi_cmd_code", got[22:19], exp[22:19]);
    check(cat, "dfi_bank_o", got[18:16], exp[18:16]);
    check(cat, "dfi_address_o", got[15:0], exp[15:0]);
  endtask

  task automatic report_test(input int idx);
    $display("test %0d %s: %s (%0d errors)", idx + 1, test_names[idx],
             (errs[idx] == 0) ? "passed" : "failed", errs[idx]);
  endtask

  // Smallest pin-to-pin gap for a previous/next command pair
  function automatic int min_gap(input logic [3:0] p, input logic [3:0] n);
    case (p)
      `DMC_LMR: return `DMC_TMRD;
      `DMC_REF: return `DMC_TRFC;
      `DMC_PRE: return `DMC_TRP;
      `DMC_ACT: begin
        case (n)
          `DMC_PRE:              return `DMC_TRAS;
          `DMC_ACT:              return `DMC_TRRD;
          `DMC_READ, `DMC_WRITE: return `DMC_TRCD;
          default:               return 1;
        endcase
      end
      `DMC_WRITE: begin
        case (n)
          `DMC_PRE:   return `DMC_TWR;
          `DMC_WRITE: return `DMC_BURST_LEN;
          `DMC_READ:  return `DMC_TWTR;
          `DMC_ACT:   return `DMC_TWR + `DMC_TRP;
          default:    return 1;
        endcase
      end
      `DMC_READ: begin
        case (n)
          `DMC_PRE:   return `DMC_TRTP;
          `DMC_WRITE: return `DMC_BURST_LEN + `DMC_TCAS;
          `DMC_READ:  return `DMC_BURST_LEN;
          `DMC_ACT:   return `DMC_TRTP + `DMC_TRP;
          default:    return 1;
        endcase
      end
      default: return 1;
    endcase
  endfunction

  function automatic logic [22:0] init_cmd(input int idx);
    case (idx)
      0:       return {`DMC_NOP, 3'd0, 16'h0};
      1:       return {`DMC_PRE, 3'd0, 16'(1) << `DMC_PRE_ALL_BIT};
      2, 3:    return {`DMC_REF, 3'd0, 16'h0};
      // CAS latency in A7:A4, burst field log2 of the burst in A3:A0
      default: return {`DMC_LMR, 3'd0, 8'h00, 4'(`DMC_TCAS), 4'($clog2(2 * `DMC_BURST_LEN))};
    endcase
  endfunction

  // Expected commands for one request, updating the bank model
  function automatic logic [2:0][22:0] ref_cmds(input logic [30:0] req);
    logic             wr;
    logic             ap;
    dmc_pkg::bank_t   b;
    dmc_pkg::row_t    r;
    dmc_pkg::col_t    c;
    logic [22:0]      col_cmd;
    logic [2:0][22:0] list;
    {wr, ap, b, r, c} = req;
    col_cmd = {(wr ? `DMC_WRITE : `DMC_READ), b, 5'd0, ap, c};
    list = {3{no_cmd_lp}};
    if (!model_open[b]) begin
      list[0] = {`DMC_ACT, b, r};
      list[1] = col_cmd;
    end else if (model_row[b] == r) begin
      list[0] = col_cmd;
    end else begin
      list[0] = {`DMC_PRE, b, 16'h0};
      list[1] = {`DMC_ACT, b, r};
      list[2] = col_cmd;
    end
    model_open[b] = !ap;
    model_row[b]  = r;
    return list;
  endfunction

  task automatic send_request(input dmc_pkg::addr_t addr, input logic wr, input logic ap);
    @(posedge dfi_clk);
    #1;
    app_addr  = addr;
    app_write = wr;
    app_ap    = ap;
    app_en    = 1'b1;
    while (app_rdy !== 1'b1) begin
      @(posedge dfi_clk);
      #1;
    end
    req_q.push_back({wr, ap, addr});
    @(posedge dfi_clk);
    #1;
    app_en = 1'b0;
  endtask

  // Monitor of the DFI pins and the data enable strobes
  always @(negedge dfi_clk) begin
    int slot;
    logic [3:0] code;
    slot = cycle_cnt % ring_lp;
    if (!dfi_clk_sync_rst) begin
      check(4, "dfi_rddata_en_o", dfi_rddata_en, exp_rd[slot]);
      check(4, "dfi_wrdata_en_o", dfi_wrdata_en, exp_wr[slot]);
      exp_rd[slot] = 1'b0;
      exp_wr[slot] = 1'b0;
      if (app_rdy && !init_calib_complete)
        note_failure(0, "app_rdy_o is high before init_calib_complete_o");
      if (!dfi_cs_n) begin
        code = {dfi_cs_n, dfi_ras_n, dfi_cas_n, dfi_we_n};
        mon_q.push_back({code, dfi_bank, dfi_address});
        mon_cyc_q.push_back(cycle_cnt);
        for (int k = 0; k < `DMC_BURST_LEN; k++) begin
          if (code == `DMC_READ)
            exp_rd[(cycle_cnt + `DMC_TCAS + k) % ring_lp] = 1'b1;
          if (code == `DMC_WRITE)
            exp_wr[(cycle_cnt + `DMC_TCAS - 1 + k) % ring_lp] = 1'b1;
        end
      end
    end
  end

  initial begin : cmd_checker
    logic [22:0]      rec;
    logic [22:0]      expd;
    logic [2:0][22:0] list;
    logic [3:0]       code;
    logic [3:0]       prev_code;
    dmc_pkg::bank_t   last_act_bank;
    int               cyc;
    int               prev_cyc;
    int               last_act_cyc;
    int               last_ref_cyc;
    int               gap;
    logic             have_prev;
    logic             have_act;
    logic             pre_all_seen;
    logic             last_ref_idle;
    logic             any_open;
    have_prev     = 1'b0;
    have_act      = 1'b0;
    pre_all_seen  = 1'b0;
    last_ref_idle = 1'b0;
    forever begin
      wait (mon_q.size() != 0);
      rec  = mon_q.pop_front();
      cyc  = mon_cyc_q.pop_front();
      code = rec[22:19];
      if (have_prev) begin
        gap = cyc - prev_cyc;
        if (gap < min_gap(prev_code, code))
          note_failure(2, $sformatf("command 0x%0h came %0d cycles after 0x%0h, minimum is %0d",
                                    code, gap, prev_code, min_gap(prev_code, code)));
      end
      if (code == `DMC_ACT) begin
        if (have_act && (cyc - last_act_cyc < `DMC_TRC))
          note_failure(2, "ACT came sooner than tRC after the previous ACT");
        if (have_act && rec[18:16] != last_act_bank && (cyc - last_act_cyc < `DMC_TRRD))
          note_failure(2, "ACT came sooner than tRRD after an ACT to another bank");
        have_act      = 1'b1;
        last_act_cyc  = cyc;
        last_act_bank = rec[18:16];
      end
      any_open = 1'b0;
      for (int b = 0; b < `DMC_NUM_BANKS; b++)
        any_open = any_open | model_open[b];
      if (init_seen < `DMC_INIT_CMDS) begin
        if (init_seen == `DMC_INIT_CMDS - 1)
          check(0, "dfi_cmd_code", code, `DMC_LMR);
        else
          compare_cmd(0, rec, init_cmd(init_seen));
        init_seen++;
      end else if (code == `DMC_PRE && rec[`DMC_PRE_ALL_BIT]) begin
        if (exp_q.size() != 0)
          note_failure(3, "PRE-all came in the middle of a request");
        pre_all_seen = 1'b1;
      end else if (code == `DMC_REF) begin
        if (exp_q.size() != 0)
          note_failure(3, "REF came in the middle of a request");
        check(3, "pre_all_issued", pre_all_seen, any_open);
        if (idle_phase && last_ref_idle && (cyc - last_ref_cyc > `DMC_TREFI + 40))
          note_failure(3, $sformatf("REF came %0d cycles after the previous one",
                                    cyc - last_ref_cyc));
        if (idle_phase)
          idle_refs++;
        last_ref_idle = idle_phase;
        last_ref_cyc  = cyc;
        pre_all_seen  = 1'b0;
        for (int b = 0; b < `DMC_NUM_BANKS; b++)
          model_open[b] = 1'b0;
      end else begin
        // The list is built only now, after any refresh that came first
        if (exp_q.size() == 0) begin
          if (req_q.size() == 0) begin
            note_failure(1, $sformatf("command 0x%0h appeared with no request pending", code));
          end else begin
            list = ref_cmds(req_q.pop_front());
            for (int k = 0; k < 3; k++)
              if (list[k] != no_cmd_lp)
                exp_q.push_back(list[k]);
          end
        end
        if (exp_q.size() != 0) begin
          expd = exp_q.pop_front();
          compare_cmd(1, rec, expd);
          if (expd[22:19] == `DMC_READ || expd[22:19] == `DMC_WRITE)
            reqs_done++;
        end
      end
      have_prev = 1'b1;
      prev_cyc  = cyc;
      prev_code = code;
    end
  end

  initial begin : watchdog
    repeat (watchdog_lp) @(posedge dfi_clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped making progress", watchdog_lp);
    $display(">>> FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] bk;
    logic [31:0] rw;
    logic [31:0] cl;
    logic [31:0] wr;
    logic [31:0] ap;
    int          pass_cnt;
    int          fail_cnt;
    dfi_clk_sync_rst = 1'b1;
    app_addr  = '0;
    app_write = 1'b0;
    app_ap    = 1'b0;
    app_en    = 1'b0;
    lfsr_q    = 32'h2808_1e31;
    for (int i = 0; i < ring_lp; i++) begin
      exp_rd[i] = 1'b0;
      exp_wr[i] = 1'b0;
    end
    for (int b = 0; b < `DMC_NUM_BANKS; b++) begin
      model_open[b] = 1'b0;
      model_row[b]  = '0;
    end
    repeat (3) @(posedge dfi_clk);
    #1;
    check(0, "init_calib_complete_o", init_calib_complete, 1'b0);
    check(0, "app_rdy_o", app_rdy, 1'b0);
    check(0, "dfi_cke_o", dfi_cke, 1'b0);
    check(0, "dfi_cs_n_o", dfi_cs_n, 1'b1);
    check(0, "dfi_ras_n_o", dfi_ras_n, 1'b1);
    check(0, "dfi_cas_n_o", dfi_cas_n, 1'b1);
    check(0, "dfi_we_n_o", dfi_we_n, 1'b1);
    check(0, "dfi_wrdata_en_o", dfi_wrdata_en, 1'b0);
    check(0, "dfi_rddata_en_o", dfi_rddata_en, 1'b0);
    dfi_clk_sync_rst = 1'b0;
    wait (init_calib_complete === 1'b1);
    wait (init_seen == `DMC_INIT_CMDS);
    report_test(0);

    // Few rows per bank so that hits and misses both occur
    for (int i = 0; i < num_rand_req_lp; i++) begin
      take_bits(3, bk);
      take_bits(2, rw);
      take_bits(10, cl);
      take_bits(1, wr);
      take_bits(1, ap);
      send_request({bk[2:0], rw[1:0], 14'h0155, cl[9:0]}, wr[0], ap[0]);
    end
    wait (reqs_done == num_rand_req_lp);
    report_test(1);

    send_request({3'd1, 16'h2000, 10'h010}, 1'b1, 1'b0);
    send_request({3'd5, 16'h4321, 10'h3f0}, 1'b0, 1'b0);
    wait (reqs_done == num_rand_req_lp + 2);
    idle_phase = 1'b1;
    repeat (idle_cycles_lp) @(posedge dfi_clk);
    idle_phase = 1'b0;
    if (idle_refs < idle_cycles_lp / (`DMC_TREFI + 40))
      note_failure(3, $sformatf("only %0d REF commands during the idle stretch", idle_refs));
    // Bank 1 was closed by refresh, so the same row needs a fresh ACT
    send_request({3'd1, 16'h2000, 10'h020}, 1'b0, 1'b1);
    wait (reqs_done == num_req_lp);
    repeat (20) @(posedge dfi_clk);
    report_test(2);
    report_test(3);
    report_test(4);

    pass_cnt = 0;
    fail_cnt = 0;
    for (int i = 0; i < 5; i++) begin
      if (errs[i] == 0)
        pass_cnt++;
      else
        fail_cnt++;
    end
    $display("Tests passed %0d, tests failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+rtl
rtl/dmc_pkg.sv
rtl/dmc_cmd_if.sv
rtl/dmc_cmd_sequencer.sv
rtl/dmc_bank_tracker.sv
rtl/dmc_cmd_queue.sv
rtl/dmc_cmd_issuer.sv
rtl/dmc_top.sv
test/tb_dmc_top.sv

// File: Bender.yml
package:
  name: dmc

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dmc_pkg.sv
      - rtl/dmc_cmd_if.sv
      - rtl/dmc_cmd_sequencer.sv
      - rtl/dmc_bank_tracker.sv
      - rtl/dmc_cmd_queue.sv
      - rtl/dmc_cmd_issuer.sv
      - rtl/dmc_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_dmc_top.sv
